/* logic/drive_pkg.sv */
package drive_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int OP_W       = 2;
    localparam int ENV_ADDR_W = 6;   // 64 samples per bank
    localparam int LEN_W      = 4;   // Sample count is field + 1
    localparam int PHASE_W    = 8;   // Top 2 bits give the quadrant
    localparam int INST_W     = 12;
    localparam int PC_W       = 5;   // 32 list entries
    localparam int AMP_W      = 8;
    localparam int IQ_SUM_W   = 10;  // Room for MAX_BANK lanes
    localparam int MAX_BANK   = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction format

    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 2'd0,
        OP_PLAY = 2'd1,
        OP_RZ   = 2'd2
    } opcode_t;

    // Opcode sits in the top bits
    localparam int OP_LSB   = INST_W - OP_W;
    // PLAY start address above the length field
    localparam int ADDR_LSB = LEN_W;
    // RZ immediate occupies [PHASE_W-1:0], PLAY length [LEN_W-1:0]

endpackage

/* logic/drive_inst_fetch.sv */
`timescale 1ns/1ps

module drive_inst_fetch #(
    parameter int NUM_BANK = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    update_pc_i,
    input  logic [NUM_BANK-1:0]                     bank_wr_sel_i,
    input  logic                                    inst_wr_en_i,
    input  logic [drive_pkg::PC_W-1:0]              inst_wr_addr_i,
    input  logic [drive_pkg::INST_W-1:0]            inst_wr_data_i,
    output logic                                    inst_valid_o,
    output logic [NUM_BANK*drive_pkg::INST_W-1:0]   inst_o
);
    import drive_pkg::*;

    localparam int LIST_DEPTH = 1 << PC_W;

    logic [PC_W-1:0] pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter, shared by all banks

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q         <= '0;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= update_pc_i;
            if (update_pc_i) begin
                pc_q <= pc_q + 1'b1; // Wraps past entry 31
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // One instruction list per bank

    genvar b;
    generate
        for (b = 0; b < NUM_BANK; b++) begin : g_list
            logic [INST_W-1:0] list_mem [LIST_DEPTH];
            logic [INST_W-1:0] inst_q;

            always_ff @(posedge clk) begin
                if (inst_wr_en_i && bank_wr_sel_i[b]) begin
                    list_mem[inst_wr_addr_i] <= inst_wr_data_i;
                end
                if (update_pc_i) begin
                    inst_q <= list_mem[pc_q]; // Word at PC before increment
                end
            end

            assign inst_o[b*INST_W +: INST_W] = inst_q;
        end
    endgenerate

endmodule

/* logic/drive_sequencer.sv */
`timescale 1ns/1ps

module drive_sequencer (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                inst_valid_i,
    input  logic [drive_pkg::INST_W-1:0]        inst_i,
    output logic                                busy_o,
    output logic                                rd_valid_o,
    output logic [drive_pkg::ENV_ADDR_W-1:0]    rd_addr_o,
    output logic [1:0]                          quadrant_o
);
    import drive_pkg::*;

    opcode_t                op;
    logic [ENV_ADDR_W-1:0]  play_addr;
    logic [LEN_W-1:0]       play_len;
    logic [PHASE_W-1:0]     rz_imm;
    logic                   is_play;
    logic                   is_rz;
    logic                   start_play;
    logic                   do_rz;

    logic                   busy_q;
    logic [LEN_W-1:0]       remain_q;
    logic [ENV_ADDR_W-1:0]  addr_q;
    logic [1:0]             quad_q;
    logic [PHASE_W-1:0]     phase_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode

    assign op        = opcode_t'(inst_i[OP_LSB +: OP_W]);
    assign play_addr = inst_i[ADDR_LSB +: ENV_ADDR_W];
    assign play_len  = inst_i[LEN_W-1:0];
    assign rz_imm    = inst_i[PHASE_W-1:0];

    always_comb begin
        is_play = 1'b0;
        is_rz   = 1'b0;
        case (op)
            OP_PLAY: is_play = inst_valid_i;
            OP_RZ:   is_rz   = inst_valid_i;
            default: ; // NOP and the unused code
        endcase
    end

    // Anything arriving mid-playback is dropped
    assign start_play = is_play & ~busy_q;
    assign do_rz      = is_rz & ~busy_q;

    ////////////////////////////////////////////////////////////////////////////
    // Virtual phase

    always_ff @(posedge clk) begin
        if (rst_i) begin
            phase_q <= '0;
        end else if (do_rz) begin
            phase_q <= phase_q + rz_imm; // Modulo 256
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Playback

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q   <= 1'b0;
            remain_q <= '0;
        end else if (busy_q) begin
            if (remain_q == '0) begin
                busy_q <= 1'b0; // Last read this cycle
            end else begin
                remain_q <= remain_q - 1'b1;
            end
        end else if (start_play) begin
            busy_q   <= 1'b1;
            remain_q <= play_len;
        end
    end

    // Read pointer and latched quadrant
    always_ff @(posedge clk) begin
        if (busy_q) begin
            addr_q <= addr_q + 1'b1;
        end else if (start_play) begin
            addr_q <= play_addr;
            quad_q <= phase_q[PHASE_W-1 -: 2];
        end
    end

    assign busy_o     = busy_q;
    assign rd_valid_o = busy_q; // One read per busy cycle
    assign rd_addr_o  = addr_q;
    assign quadrant_o = quad_q;

endmodule

/* logic/drive_iq_modulator.sv */
`timescale 1ns/1ps

module drive_iq_modulator (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                env_wr_en_i,
    input  logic [drive_pkg::ENV_ADDR_W-1:0]    env_wr_addr_i,
    input  logic [drive_pkg::AMP_W-1:0]         env_wr_data_i,
    input  logic                                rd_valid_i,
    input  logic [drive_pkg::ENV_ADDR_W-1:0]    rd_addr_i,
    input  logic [1:0]                          quadrant_i,
    output logic                                valid_o,
    output logic [drive_pkg::AMP_W-1:0]         i_o,
    output logic [drive_pkg::AMP_W-1:0]         q_o
);
    import drive_pkg::*;

    localparam int ENV_DEPTH = 1 << ENV_ADDR_W;

    logic [AMP_W-1:0] env_mem [ENV_DEPTH];
    logic [AMP_W-1:0] sample;

    always_ff @(posedge clk) begin
        if (env_wr_en_i) begin
            env_mem[env_wr_addr_i] <= env_wr_data_i;
        end
    end

    assign sample = env_mem[rd_addr_i];

    ////////////////////////////////////////////////////////////////////////////
    // Quadrant rotation, -128 negates to itself

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            i_o     <= '0;
            q_o     <= '0;
        end else begin
            valid_o <= rd_valid_i;
            i_o     <= '0;
            q_o     <= '0;
            if (rd_valid_i) begin
                case (quadrant_i)
                    2'd0: i_o <= sample;       // 0 deg
                    2'd1: q_o <= sample;       // 90 deg
                    2'd2: i_o <= -sample;      // 180 deg
                    default: q_o <= -sample;   // 270 deg
                endcase
            end
        end
    end

endmodule

/* logic/drive_bank_sum.sv */
`timescale 1ns/1ps

module drive_bank_sum #(
    parameter int NUM_BANK = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic [NUM_BANK-1:0]                     lane_valid_i,
    input  logic [NUM_BANK*drive_pkg::AMP_W-1:0]    lane_i_i,
    input  logic [NUM_BANK*drive_pkg::AMP_W-1:0]    lane_q_i,
    output logic                                    valid_o,
    output logic [drive_pkg::IQ_SUM_W-1:0]          i_o,
    output logic [drive_pkg::IQ_SUM_W-1:0]          q_o
);
    import drive_pkg::*;

    logic signed [IQ_SUM_W-1:0] i_acc;
    logic signed [IQ_SUM_W-1:0] q_acc;

    // Sum width only covers up to MAX_BANK lanes
    generate
        if (NUM_BANK < 1 || NUM_BANK > MAX_BANK) begin : g_bank_check
            $error("drive_bank_sum: NUM_BANK out of range");
        end
    endgenerate

    always_comb begin
        logic signed [AMP_W-1:0] li;
        logic signed [AMP_W-1:0] lq;
        i_acc = '0;
        q_acc = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            li = lane_i_i[b*AMP_W +: AMP_W];
            lq = lane_q_i[b*AMP_W +: AMP_W];
            if (lane_valid_i[b]) begin
                i_acc = i_acc + li; // Sign extended
                q_acc = q_acc + lq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            i_o     <= '0;
            q_o     <= '0;
        end else begin
            valid_o <= |lane_valid_i;
            i_o     <= i_acc;
            q_o     <= q_acc;
        end
    end

endmodule

/* logic/drive_datapath.sv */
`timescale 1ns/1ps

module drive_datapath #(
    parameter int NUM_BANK = 2
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                update_pc_i,
    input  logic [NUM_BANK-1:0]                 bank_wr_sel_i,
    input  logic                                inst_wr_en_i,
    input  logic [drive_pkg::PC_W-1:0]          inst_wr_addr_i,
    input  logic [drive_pkg::INST_W-1:0]        inst_wr_data_i,
    input  logic                                env_wr_en_i,
    input  logic [drive_pkg::ENV_ADDR_W-1:0]    env_wr_addr_i,
    input  logic [drive_pkg::AMP_W-1:0]         env_wr_data_i,
    output logic [NUM_BANK-1:0]                 bank_busy_o,
    output logic                                valid_o,
    output logic [drive_pkg::IQ_SUM_W-1:0]      i_o,
    output logic [drive_pkg::IQ_SUM_W-1:0]      q_o
);
    import drive_pkg::*;

    logic                       inst_valid;
    logic [NUM_BANK*INST_W-1:0] inst;
    logic [NUM_BANK-1:0]        lane_valid;
    logic [NUM_BANK*AMP_W-1:0]  lane_i;
    logic [NUM_BANK*AMP_W-1:0]  lane_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch

    drive_inst_fetch #(
        .NUM_BANK(NUM_BANK)
    ) u_fetch (
        .clk(clk),
        .rst_i(rst_i),
        .update_pc_i(update_pc_i),
        .bank_wr_sel_i(bank_wr_sel_i),
        .inst_wr_en_i(inst_wr_en_i),
        .inst_wr_addr_i(inst_wr_addr_i),
        .inst_wr_data_i(inst_wr_data_i),
        .inst_valid_o(inst_valid),
        .inst_o(inst)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-bank sequencer and modulator

    genvar b;
    generate
        for (b = 0; b < NUM_BANK; b++) begin : g_bank
            logic                   rd_valid;
            logic [ENV_ADDR_W-1:0]  rd_addr;
            logic [1:0]             quadrant;
            logic                   env_wr_en;

            assign env_wr_en = env_wr_en_i & bank_wr_sel_i[b];

            drive_sequencer u_seq (
                .clk(clk),
                .rst_i(rst_i),
                .inst_valid_i(inst_valid),
                .inst_i(inst[b*INST_W +: INST_W]),
                .busy_o(bank_busy_o[b]),
                .rd_valid_o(rd_valid),
                .rd_addr_o(rd_addr),
                .quadrant_o(quadrant)
            );

            drive_iq_modulator u_mod (
                .clk(clk),
                .rst_i(rst_i),
                .env_wr_en_i(env_wr_en),
                .env_wr_addr_i(env_wr_addr_i),
                .env_wr_data_i(env_wr_data_i),
                .rd_valid_i(rd_valid),
                .rd_addr_i(rd_addr),
                .quadrant_i(quadrant),
                .valid_o(lane_valid[b]),
                .i_o(lane_i[b*AMP_W +: AMP_W]),
                .q_o(lane_q[b*AMP_W +: AMP_W])
            );
        end
    endgenerate

    drive_bank_sum #(
        .NUM_BANK(NUM_BANK)
    ) u_sum (
        .clk(clk),
        .rst_i(rst_i),
        .lane_valid_i(lane_valid),
        .lane_i_i(lane_i),
        .lane_q_i(lane_q),
        .valid_o(valid_o),
        .i_o(i_o),
        .q_o(q_o)
    );

endmodule

/* tests/drive_datapath_assert.sv */
`timescale 1ns/1ps

module drive_datapath_assert #(
    parameter int NUM_BANK = 2
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                update_pc_i,
    input  logic [NUM_BANK-1:0]                 bank_busy_i,
    input  logic                                valid_i,
    input  logic [drive_pkg::IQ_SUM_W-1:0]      i_i,
    input  logic [drive_pkg::IQ_SUM_W-1:0]      q_i
);

    // Controller holds off while any PLAY is draining
    a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst_i)
        update_pc_i |-> (bank_busy_i == '0))
        else $error("update_pc_i strobed while bank_busy_o = %h", bank_busy_i);

    a_idle_zero: assert property (@(posedge clk) disable iff (rst_i)
        !valid_i |-> (i_i == '0 && q_i == '0))
        else $error("I/Q output nonzero while valid_o is low");

    a_reset_quiet: assert property (@(posedge clk) rst_i |=> !valid_i)
        else $error("valid_o high in the cycle after reset");

endmodule

bind drive_datapath drive_datapath_assert #(
    .NUM_BANK(NUM_BANK)
) u_assert (
    .clk(clk),
    .rst_i(rst_i),
    .update_pc_i(update_pc_i),
    .bank_busy_i(bank_busy_o),
    .valid_i(valid_o),
    .i_i(i_o),
    .q_i(q_o)
);

/* tests/drive_datapath_tb.sv */
`timescale 1ns/1ps

module drive_datapath_tb;
    import drive_pkg::*;

    localparam int NUM_BANK        = 2;
    localparam int NUM_STROBES     = 40;  // One pass over the list plus a PC wrap
    localparam int LIST_DEPTH      = 1 << PC_W;
    localparam int ENV_DEPTH       = 1 << ENV_ADDR_W;
    localparam int LOAD_CYCLES     = NUM_BANK * (ENV_DEPTH + LIST_DEPTH);
    localparam int WATCHDOG_CYCLES = NUM_STROBES * (16 + 4 + 4) + LOAD_CYCLES + 200;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   update_pc_i;
    logic [NUM_BANK-1:0]    bank_wr_sel_i;
    logic                   inst_wr_en_i;
    logic [PC_W-1:0]        inst_wr_addr_i;
    logic [INST_W-1:0]      inst_wr_data_i;
    logic                   env_wr_en_i;
    logic [ENV_ADDR_W-1:0]  env_wr_addr_i;
    logic [AMP_W-1:0]       env_wr_data_i;
    logic [NUM_BANK-1:0]    bank_busy_o;
    logic                   valid_o;
    logic [IQ_SUM_W-1:0]    i_o;
    logic [IQ_SUM_W-1:0]    q_o;

    // Reference model state
    logic [INST_W-1:0]      prog [NUM_BANK][LIST_DEPTH];
    logic [AMP_W-1:0]       env [NUM_BANK][ENV_DEPTH];
    logic [PHASE_W-1:0]     phase [NUM_BANK];
    int                     free_at [NUM_BANK];   // First cycle the sequencer takes a word
    int                     pc = 0;
    bit                     chain [LIST_DEPTH];   // Next strobe follows with no gap
    bit                     exp_v_map [int];
    int                     exp_i_map [int];
    int                     exp_q_map [int];
    int                     exp_busy_map [int];

    int                     cyc = 0;
    int                     errors = 0;
    logic [31:0]            rng = 32'd82;
    logic                   exp_valid = 1'b0;
    logic [IQ_SUM_W-1:0]    exp_i = '0;
    logic [IQ_SUM_W-1:0]    exp_q = '0;
    logic [NUM_BANK-1:0]    exp_busy = '0;

    drive_datapath #(
        .NUM_BANK(NUM_BANK)
    ) DUT (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [INST_W-1:0] enc_play(input int addr, input int n);
        return {OP_PLAY, ENV_ADDR_W'(addr), LEN_W'(n - 1)};
    endfunction

    function automatic logic [INST_W-1:0] enc_rz(input int imm);
        return {OP_RZ, 2'b00, PHASE_W'(imm)};
    endfunction

    // Quadrant table, negation wraps in 8 bits
    function automatic void rotate(input logic [AMP_W-1:0] a, input logic [1:0] quad,
                                   output int i_val, output int q_val);
        int pos;
        int neg;
        pos   = int'(signed'(a));
        neg   = (pos == -128) ? -128 : -pos;
        i_val = (quad == 2'd0) ? pos : ((quad == 2'd2) ? neg : 0);
        q_val = (quad == 2'd1) ? pos : ((quad == 2'd3) ? neg : 0);
    endfunction

    task automatic report_value(input string name, input logic [IQ_SUM_W-1:0] exp,
                                input logic [IQ_SUM_W-1:0] got);
        errors++;
        $display("[FAIL] %s expected %h got %h at cycle %0d", name, exp, got, cyc);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, run once per strobe sampled at cycle c

    task automatic model_fetch(input int c);
        logic [INST_W-1:0]     word;
        logic [ENV_ADDR_W-1:0] addr;
        int                    n;
        int                    iv;
        int                    qv;
        int                    t;
        for (int b = 0; b < NUM_BANK; b++) begin
            word = prog[b][pc];
            if (c + 1 >= free_at[b]) begin  // Dropped while a PLAY is running
                if (word[11:10] == OP_RZ) begin
                    phase[b] = phase[b] + word[7:0];
                end else if (word[11:10] == OP_PLAY) begin
                    n    = int'(word[3:0]) + 1;
                    addr = word[9:4];
                    for (int k = 0; k < n; k++) begin
                        t = c + 4 + k;
                        rotate(env[b][addr], phase[b][7:6], iv, qv);
                        if (!exp_v_map.exists(t)) begin
                            exp_v_map[t] = 1'b1;
                            exp_i_map[t] = 0;
                            exp_q_map[t] = 0;
                        end
                        exp_i_map[t] = exp_i_map[t] + iv;
                        exp_q_map[t] = exp_q_map[t] + qv;
                        if (!exp_busy_map.exists(c + 2 + k)) begin
                            exp_busy_map[c + 2 + k] = 0;
                        end
                        exp_busy_map[c + 2 + k] = exp_busy_map[c + 2 + k] | (1 << b);
                        addr++;
                    end
                    free_at[b] = c + 2 + n;
                end
            end
        end
        pc = (pc + 1) % LIST_DEPTH;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (exp_v_map.exists(cyc + 1)) begin
            exp_valid <= 1'b1;
            exp_i     <= IQ_SUM_W'(exp_i_map[cyc + 1]);
            exp_q     <= IQ_SUM_W'(exp_q_map[cyc + 1]);
        end else begin
            exp_valid <= 1'b0;
            exp_i     <= '0;
            exp_q     <= '0;
        end
        if (exp_busy_map.exists(cyc + 1)) begin
            exp_busy <= NUM_BANK'(exp_busy_map[cyc + 1]);
        end else begin
            exp_busy <= '0;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst_i) valid_o == exp_valid)
        else report_value("valid_o", $sampled(exp_valid), $sampled(valid_o));
    a_i: assert property (@(posedge clk) disable iff (rst_i) i_o == exp_i)
        else report_value("i_o", $sampled(exp_i), $sampled(i_o));
    a_q: assert property (@(posedge clk) disable iff (rst_i) q_o == exp_q)
        else report_value("q_o", $sampled(exp_q), $sampled(q_o));
    a_busy: assert property (@(posedge clk) disable iff (rst_i) bank_busy_o == exp_busy)
        else report_value("bank_busy_o", $sampled(exp_busy), $sampled(bank_busy_o));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic build_program();
        logic [31:0] r;
        for (int b = 0; b < NUM_BANK; b++) begin
            for (int a = 0; a < ENV_DEPTH; a++) begin
                env[b][a] = AMP_W'(next_rand());
            end
            for (int a = 0; a < LIST_DEPTH; a++) begin
                r = next_rand();
                prog[b][a] = '0;
                if (a >= 15 && r % 3 == 1) begin
                    prog[b][a] = enc_play(int'(r[15:10]), int'(r[9:6]) + 1);
                end else if (a >= 15 && r % 3 == 2) begin
                    prog[b][a] = enc_rz(int'(r[23:16]));
                end
            end
        end
        env[0][30]  = 8'h80;           // Most negative sample at 180 deg
        prog[0][0]  = enc_play(0, 6);
        prog[1][1]  = enc_play(10, 3);
        prog[0][2]  = enc_rz(64);
        prog[1][2]  = enc_rz(200);
        prog[0][3]  = enc_play(20, 4);  // 90 deg
        prog[0][4]  = enc_rz(64);
        prog[0][5]  = enc_play(30, 16); // 180 deg, full length
        prog[0][6]  = enc_rz(64);
        prog[1][6]  = enc_rz(56);       // Bank 1 wraps back to 0
        prog[0][7]  = enc_play(60, 8);  // Address wraps past 63
        prog[1][7]  = enc_play(5, 8);
        prog[0][8]  = enc_rz(100);
        prog[1][8]  = enc_rz(192);
        prog[0][9]  = enc_play(40, 10);
        prog[1][9]  = enc_play(40, 10);
        prog[0][11] = enc_rz(32);
        prog[1][11] = enc_rz(32);
        prog[0][12] = enc_play(50, 5);
        prog[1][12] = enc_play(50, 5);
        prog[0][13] = enc_play(0, 4);
        prog[0][14] = enc_play(8, 3);   // Arrives while busy, dropped
        prog[1][14] = enc_play(16, 2);
        chain[10]   = 1'b1;
        chain[11]   = 1'b1;
        chain[13]   = 1'b1;
    endtask

    task automatic load_memories();
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_wr_sel_i = NUM_BANK'(1 << b);
            for (int a = 0; a < ENV_DEPTH; a++) begin
                env_wr_en_i   = 1'b1;
                env_wr_addr_i = ENV_ADDR_W'(a);
                env_wr_data_i = env[b][a];
                @(negedge clk);
            end
            env_wr_en_i = 1'b0;
            for (int a = 0; a < LIST_DEPTH; a++) begin
                inst_wr_en_i   = 1'b1;
                inst_wr_addr_i = PC_W'(a);
                inst_wr_data_i = prog[b][a];
                @(negedge clk);
            end
            inst_wr_en_i = 1'b0;
        end
        bank_wr_sel_i = '0;
    endtask

    task automatic issue_strobe();
        update_pc_i = 1'b1;
        model_fetch(cyc);
        @(negedge clk);
        update_pc_i = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);  // Busy shows one cycle after fetch
        while (bank_busy_o != '0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst_i          = 1'b1;
        update_pc_i    = 1'b0;
        bank_wr_sel_i  = '0;
        inst_wr_en_i   = 1'b0;
        inst_wr_addr_i = '0;
        inst_wr_data_i = '0;
        env_wr_en_i    = 1'b0;
        env_wr_addr_i  = '0;
        env_wr_data_i  = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            phase[b]   = '0;
            free_at[b] = 0;
        end
        build_program();
        repeat (4) @(negedge clk);
        rst_i = 1'b0;
        repeat (3) @(negedge clk);
        load_memories();
        for (int s = 0; s < NUM_STROBES; s++) begin
            issue_strobe();
            if (!chain[s % LIST_DEPTH]) begin
                wait_idle();
            end
        end
        repeat (8) @(negedge clk); // Drain the four pipeline stages
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* src.f */
logic/drive_pkg.sv
logic/drive_inst_fetch.sv
logic/drive_sequencer.sv
logic/drive_iq_modulator.sv
logic/drive_bank_sum.sv
logic/drive_datapath.sv
tests/drive_datapath_assert.sv
tests/drive_datapath_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module drive_datapath_tb -f src.f \
    || { echo "Build failed"; exit 1; }
./obj_dir/Vdrive_datapath_tb > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "ERRORS FOUND" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
